//--- all.f
src/stepper_pkg.sv
src/motor_cmd_if.sv
src/ramp_if.sv
src/speed_table.sv
src/ramp_timer.sv
src/motion_channel.sv
src/step_motor.sv
testbench/step_motor_sva.sv
testbench/test_step_motor.sv

//--- Makefile
TOP = test_step_motor

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- testbench/test_step_motor.sv
`timescale 1ns/100ps

module test_step_motor;

	localparam int SW = 16;
	localparam int AW = 4;
	localparam int MW = 3;
	localparam int DIV = 8;
	localparam int DEPTH = 2 ** AW;
	localparam logic [7:0] ZPD_SEQ = 8'b1100_1010;
	localparam int MOVE_LIMIT = 30000;	// cycles per move before giving up
	localparam int ROUNDS = 12;

	logic          ctl_clk;
	logic          resetn;
	logic          br_init;
	logic          br_wr_en;
	logic [SW-1:0] br_data;
	logic [1:0]    zpd;
	logic [1:0]    start;
	logic [1:0]    stop;
	logic [1:0]    dir;
	logic [1:0]    xen;
	logic [1:0]    xrst;
	logic [MW-1:0] ms [2];
	logic [SW-1:0] stroke [2];
	logic [SW-1:0] speed [2];
	logic [SW-1:0] step [2];
	wire  [1:0]    drive;
	wire  [1:0]    m_dir;
	wire  [1:0]    m_xen;
	wire  [1:0]    m_xrst;
	wire  [1:0]    ready;
	wire  [1:0]    zpsign;
	wire  [1:0]    tpsign;
	wire  [MW-1:0] m_ms [2];
	wire  [SW-1:0] pos [2];

	integer        seed;
	int            tbl [DEPTH];	// model copy of the speed table
	int            model_pos [2];
	bit            model_zp [2];
	int            p_steps [2];
	int            p_floor [2];
	bit            p_fwd [2];
	logic [MW-1:0] p_ms [2];
	int            p_stop [2];	// cycle of the stop request or -1 for none
	bit            p_zero [2];

	step_motor #(
		.C_STEP_NUMBER_WIDTH  (SW),
		.C_SPEED_DATA_WIDTH   (SW),
		.C_SPEED_ADDRESS_WIDTH(AW),
		.C_MICROSTEP_WIDTH    (MW),
		.C_CLK_DIV_NBR        (DIV),
		.C_ZPD_SEQ            (ZPD_SEQ)
	) UUT (
		.ctl_clk  (ctl_clk),
		.resetn   (resetn),
		.br_init  (br_init),
		.br_wr_en (br_wr_en),
		.br_data  (br_data),
		.m0_zpd   (zpd[0]),
		.m0_drive (drive[0]),
		.m0_dir   (m_dir[0]),
		.m0_ms    (m_ms[0]),
		.m0_xen   (m_xen[0]),
		.m0_xrst  (m_xrst[0]),
		.s0_zpsign(zpsign[0]),
		.s0_tpsign(tpsign[0]),
		.s0_ready (ready[0]),
		.s0_pos   (pos[0]),
		.s0_stroke(stroke[0]),
		.s0_speed (speed[0]),
		.s0_step  (step[0]),
		.s0_start (start[0]),
		.s0_stop  (stop[0]),
		.s0_dir   (dir[0]),
		.s0_ms    (ms[0]),
		.s0_xen   (xen[0]),
		.s0_xrst  (xrst[0]),
		.m1_zpd   (zpd[1]),
		.m1_drive (drive[1]),
		.m1_dir   (m_dir[1]),
		.m1_ms    (m_ms[1]),
		.m1_xen   (m_xen[1]),
		.m1_xrst  (m_xrst[1]),
		.s1_zpsign(zpsign[1]),
		.s1_tpsign(tpsign[1]),
		.s1_ready (ready[1]),
		.s1_pos   (pos[1]),
		.s1_stroke(stroke[1]),
		.s1_speed (speed[1]),
		.s1_step  (step[1]),
		.s1_start (start[1]),
		.s1_stop  (stop[1]),
		.s1_dir   (dir[1]),
		.s1_ms    (ms[1]),
		.s1_xen   (xen[1]),
		.s1_xrst  (xrst[1])
	);

	bind motion_channel step_motor_sva #(
		.C_STEP_NUMBER_WIDTH(C_STEP_NUMBER_WIDTH)
	) u_sva (
		.ctl_clk(ctl_clk),
		.resetn (resetn),
		.br_init(br_init),
		.state  (state),
		.drive  (drive),
		.pos    (pos),
		.stroke (stroke)
	);

	always #50 ctl_clk = ~ctl_clk;

	// ========================================================================
	// reporting and reference model
	// ========================================================================

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_eq(input string pfx, input int m, input string sig,
			input int got, input int exp);
		assert (got == exp) else
			fail_run($sformatf("MISMATCH at %0d ns: %s%0d_%s = %0d, expected %0d",
				$time, pfx, m, sig, got, exp));
	endtask

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// cycles of step k as the ramp runs up from the start and down to the end
	function automatic int period_cycles(input int k, input int total, input int floor_v);
		int i;
		int p;
		i = (k < total - 1 - k) ? k : total - 1 - k;
		if (i > DEPTH - 1)
			i = DEPTH - 1;
		p = (tbl[i] > floor_v) ? tbl[i] : floor_v;
		if (p == 0)
			p = 1;
		return DIV * p;
	endfunction

	function automatic int clip_steps(input int m, input int n, input bit fwd);
		int room;
		room = fwd ? int'(stroke[m]) - model_pos[m] : model_pos[m];
		if (room < 0)
			room = 0;
		return (n < room) ? n : room;
	endfunction

	// ========================================================================
	// stimulus tasks
	// ========================================================================

	task automatic check_after_reset();
		@(negedge ctl_clk);
		for (int m = 0; m < 2; m++) begin
			check_eq("m", m, "drive", drive[m], 0);
			check_eq("m", m, "xen", m_xen[m], 0);
			check_eq("m", m, "xrst", m_xrst[m], 0);
			check_eq("s", m, "zpsign", zpsign[m], 0);
			check_eq("s", m, "pos", pos[m], 0);
			check_eq("s", m, "ready", ready[m], 1);
		end
	endtask

	task automatic load_table();
		@(posedge ctl_clk);
		#10;
		br_init = 1'b1;	// write address back to zero
		@(posedge ctl_clk);
		#10;
		br_init = 1'b0;
		for (int i = 0; i < DEPTH; i++) begin
			br_wr_en = 1'b1;
			br_data  = SW'(tbl[i]);
			@(posedge ctl_clk);
			#10;
		end
		br_wr_en = 1'b0;
	endtask

	task automatic offer_during_init();
		@(posedge ctl_clk);
		#10;
		br_init = 1'b1;
		start   = 2'b11;
		dir     = 2'b11;
		for (int m = 0; m < 2; m++)
			step[m] = 16'd5;
		repeat (12) begin
			@(negedge ctl_clk);
			assert (ready == 2'b00 && drive == 2'b00) else
				fail_run("a channel was ready or moving while the table was in init");
		end
		@(posedge ctl_clk);
		#10;
		start   = '0;
		br_init = 1'b0;
		repeat (40) begin
			@(negedge ctl_clk);
			assert (ready == 2'b11 && drive == 2'b00) else
				fail_run("a channel moved after a command offered during table init");
		end
	endtask

	task automatic wait_ready(input int m);
		int n;
		n = 0;
		@(negedge ctl_clk);
		while (!ready[m]) begin
			n++;
			if (n > 2000)
				fail_run($sformatf("timeout: motor %0d never became ready", m));
			@(negedge ctl_clk);
		end
	endtask

	task automatic pick_command(input int m);
		int mode;
		mode       = rand_below(4);	// 0 and 1 plain, 2 stop, 3 zero point
		p_fwd[m]   = rand_below(2) != 0;
		p_steps[m] = rand_below(41);
		p_floor[m] = rand_below(16);
		p_ms[m]    = MW'(rand_below(8));
		p_stop[m]  = (mode == 2) ? rand_below(400) : -1;
		p_zero[m]  = (mode == 3) && (model_pos[m] > 0);
		if (p_zero[m]) begin
			p_fwd[m] = 1'b0;
			if (p_steps[m] == 0)
				p_steps[m] = 1;
		end
	endtask

	task automatic run_move(input int m, input int steps_v, input int floor_v, input bit fwd,
			input logic [MW-1:0] ms_v, input int stop_at, input bit zero_mode);
		int total;
		int expect_n;
		int cnt;
		int due;
		int n;
		int pulses;
		int last;
		int start_pos;
		int offer_at;
		logic xen_q;
		logic xrst_q;
		total     = clip_steps(m, steps_v, fwd);
		start_pos = model_pos[m];
		expect_n  = (zero_mode && total > 0) ? 1 : total;
		if (stop_at >= 0) begin	// steps done by the stop cycle, plus one
			due = 0;
			cnt = 0;
			for (int k = 0; k < total; k++) begin
				due += period_cycles(k, total, floor_v);
				if (due <= stop_at)
					cnt++;
			end
			expect_n = (cnt + 1 < total) ? cnt + 1 : total;
		end

		wait_ready(m);
		@(posedge ctl_clk);
		#10;
		start[m] = 1'b1;
		step[m]  = SW'(steps_v);
		speed[m] = SW'(floor_v);
		dir[m]   = fwd;
		ms[m]    = ms_v;
		@(negedge ctl_clk);
		assert (ready[m]) else
			fail_run($sformatf("motor %0d dropped ready before taking the command", m));
		@(posedge ctl_clk);	// acceptance edge
		#10;
		start[m] = 1'b0;
		if (fwd)
			model_zp[m] = 1'b0;

		n        = 0;
		pulses   = 0;
		last     = 0;
		due      = (total > 0) ? period_cycles(0, total, floor_v) : -1;
		offer_at = (total > 0) ? 4 : -1;	// a busy channel must ignore this one
		forever begin
			if (n > 0) begin
				@(posedge ctl_clk);
				#10;
			end
			xen_q    = xen[m];
			xrst_q   = xrst[m];
			xen[m]   = n[2] ^ m[0];
			xrst[m]  = n[3];
			stop[m]  = n == stop_at;
			zpd[m]   = (zero_mode && n < 8) ? ZPD_SEQ[7 - n] : 1'b0;
			start[m] = n == offer_at;
			if (n == offer_at) begin
				dir[m] = !fwd;
				ms[m]  = ~ms_v;
			end
			@(negedge ctl_clk);
			check_eq("m", m, "xen", m_xen[m], xen_q);
			check_eq("m", m, "xrst", m_xrst[m], xrst_q);
			check_eq("m", m, "dir", m_dir[m], fwd);
			check_eq("m", m, "ms", m_ms[m], ms_v);
			if (drive[m]) begin
				check_eq("m", m, "drive cycle", n, due);
				pulses++;
				last = n;
				due  = (pulses < total) ? due + period_cycles(pulses, total, floor_v) : -1;
			end
			if (ready[m])
				break;
			n++;
			if (n > MOVE_LIMIT)
				fail_run($sformatf("timeout: motor %0d move never finished", m));
		end
		@(posedge ctl_clk);
		#10;
		stop[m]  = 1'b0;
		zpd[m]   = 1'b0;
		start[m] = 1'b0;

		check_eq("s", m, "ready cycle", n, last + 2);	// one cycle after done
		check_eq("m", m, "drive count", pulses, expect_n);
		if (zero_mode && total > 0) begin
			model_pos[m] = 0;
			model_zp[m]  = 1'b1;
		end else begin
			model_pos[m] = fwd ? start_pos + expect_n : start_pos - expect_n;
		end
		check_eq("s", m, "pos", pos[m], model_pos[m]);
		check_eq("s", m, "zpsign", zpsign[m], model_zp[m]);
		check_eq("s", m, "tpsign", tpsign[m], model_pos[m] == int'(stroke[m]));
	endtask

	// ========================================================================
	// main sequence
	// ========================================================================

	initial begin
		seed     = 32'ha449_928e;
		ctl_clk  = 1'b0;
		resetn   = 1'b0;
		br_init  = 1'b0;
		br_wr_en = 1'b0;
		br_data  = '0;
		zpd      = '0;
		start    = '0;
		stop     = '0;
		dir      = '0;
		xen      = '0;
		xrst     = '0;
		for (int m = 0; m < 2; m++) begin
			ms[m]        = '0;
			speed[m]     = '0;
			step[m]      = '0;
			stroke[m]    = SW'(20 + rand_below(24));
			model_pos[m] = 0;
			model_zp[m]  = 1'b0;
		end
		tbl[0] = 30 + rand_below(8);	// slow first entry, faster towards cruise
		for (int i = 1; i < DEPTH; i++) begin
			tbl[i] = tbl[i-1] - 1 - rand_below(2);
			if (tbl[i] < 2)
				tbl[i] = 2;
		end

		repeat (3) @(posedge ctl_clk);
		#10;
		resetn = 1'b1;
		check_after_reset();
		load_table();
		offer_during_init();

		for (int r = 0; r < ROUNDS; r++) begin
			for (int m = 0; m < 2; m++)
				pick_command(m);
			fork
				run_move(0, p_steps[0], p_floor[0], p_fwd[0], p_ms[0], p_stop[0], p_zero[0]);
				run_move(1, p_steps[1], p_floor[1], p_fwd[1], p_ms[1], p_stop[1], p_zero[1]);
			join
		end

		$display("No errors");
		$finish;
	end

endmodule

//--- testbench/step_motor_sva.sv
`timescale 1ns/100ps

module step_motor_sva #(
	parameter int C_STEP_NUMBER_WIDTH = 16
) (
	input logic                           ctl_clk,
	input logic                           resetn,
	input logic                           br_init,
	input stepper_pkg::run_state_e        state,
	input logic                           drive,
	input logic [C_STEP_NUMBER_WIDTH-1:0] pos,
	input logic [C_STEP_NUMBER_WIDTH-1:0] stroke
);
	logic ready;

	assign ready = (state == stepper_pkg::IDLE) && !br_init;	// same rule as the command port

	a_drive_not_ready: assert property (@(posedge ctl_clk) disable iff (!resetn)
		drive |-> !ready)
		else $error("drive pulse while the channel reports ready");

	a_pos_in_stroke: assert property (@(posedge ctl_clk) disable iff (!resetn)
		pos <= stroke)
		else $error("position is beyond the stroke");

	a_drive_single: assert property (@(posedge ctl_clk) disable iff (!resetn)
		drive |=> !drive)
		else $error("drive high in two consecutive cycles");

	a_drive_after_reset: assert property (@(posedge ctl_clk)
		!resetn |=> !drive)
		else $error("drive high in the cycle after reset");

endmodule

//--- src/step_motor.sv
`timescale 1ns/100ps

module step_motor #(
	parameter int C_STEP_NUMBER_WIDTH   = 16,
	parameter int C_SPEED_DATA_WIDTH    = 16,
	parameter int C_SPEED_ADDRESS_WIDTH = 4,
	parameter int C_MICROSTEP_WIDTH     = 3,
	parameter int C_CLK_DIV_NBR         = 8,
	parameter logic [stepper_pkg::ZPD_LEN-1:0] C_ZPD_SEQ = 8'b1100_1010
) (
	input  logic                           ctl_clk,
	input  logic                           resetn,

	input  logic                           br_init,
	input  logic                           br_wr_en,
	input  logic [C_SPEED_DATA_WIDTH-1:0]  br_data,

	input  logic                           m0_zpd,
	output logic                           m0_drive,
	output logic                           m0_dir,
	output logic [C_MICROSTEP_WIDTH-1:0]   m0_ms,
	output logic                           m0_xen,
	output logic                           m0_xrst,

	output logic                           s0_zpsign,
	output logic                           s0_tpsign,
	output logic                           s0_ready,
	output logic [C_STEP_NUMBER_WIDTH-1:0] s0_pos,
	input  logic [C_STEP_NUMBER_WIDTH-1:0] s0_stroke,
	input  logic [C_SPEED_DATA_WIDTH-1:0]  s0_speed,
	input  logic [C_STEP_NUMBER_WIDTH-1:0] s0_step,
	input  logic                           s0_start,
	input  logic                           s0_stop,
	input  logic                           s0_dir,
	input  logic [C_MICROSTEP_WIDTH-1:0]   s0_ms,
	input  logic                           s0_xen,
	input  logic                           s0_xrst,

	input  logic                           m1_zpd,
	output logic                           m1_drive,
	output logic                           m1_dir,
	output logic [C_MICROSTEP_WIDTH-1:0]   m1_ms,
	output logic                           m1_xen,
	output logic                           m1_xrst,

	output logic                           s1_zpsign,
	output logic                           s1_tpsign,
	output logic                           s1_ready,
	output logic [C_STEP_NUMBER_WIDTH-1:0] s1_pos,
	input  logic [C_STEP_NUMBER_WIDTH-1:0] s1_stroke,
	input  logic [C_SPEED_DATA_WIDTH-1:0]  s1_speed,
	input  logic [C_STEP_NUMBER_WIDTH-1:0] s1_step,
	input  logic                           s1_start,
	input  logic                           s1_stop,
	input  logic                           s1_dir,
	input  logic [C_MICROSTEP_WIDTH-1:0]   s1_ms,
	input  logic                           s1_xen,
	input  logic                           s1_xrst
);
	logic [C_SPEED_ADDRESS_WIDTH-1:0] rd_addr0;
	logic [C_SPEED_ADDRESS_WIDTH-1:0] rd_addr1;
	logic [C_SPEED_DATA_WIDTH-1:0]    rd_data0;
	logic [C_SPEED_DATA_WIDTH-1:0]    rd_data1;

	motor_cmd_if #(
		.C_STEP_NUMBER_WIDTH(C_STEP_NUMBER_WIDTH),
		.C_SPEED_DATA_WIDTH (C_SPEED_DATA_WIDTH),
		.C_MICROSTEP_WIDTH  (C_MICROSTEP_WIDTH)
	) cmd0 ();

	motor_cmd_if #(
		.C_STEP_NUMBER_WIDTH(C_STEP_NUMBER_WIDTH),
		.C_SPEED_DATA_WIDTH (C_SPEED_DATA_WIDTH),
		.C_MICROSTEP_WIDTH  (C_MICROSTEP_WIDTH)
	) cmd1 ();

	// ========================================================================
	// command ports onto the interfaces
	// ========================================================================

	assign cmd0.valid = s0_start;
	assign cmd0.speed = s0_speed;
	assign cmd0.steps = s0_step;
	assign cmd0.dir   = s0_dir;
	assign cmd0.ms    = s0_ms;
	assign cmd0.stop  = s0_stop;
	assign s0_ready   = cmd0.ready;

	assign cmd1.valid = s1_start;
	assign cmd1.speed = s1_speed;
	assign cmd1.steps = s1_step;
	assign cmd1.dir   = s1_dir;
	assign cmd1.ms    = s1_ms;
	assign cmd1.stop  = s1_stop;
	assign s1_ready   = cmd1.ready;

	speed_table #(
		.C_SPEED_DATA_WIDTH   (C_SPEED_DATA_WIDTH),
		.C_SPEED_ADDRESS_WIDTH(C_SPEED_ADDRESS_WIDTH)
	) u_table (
		.ctl_clk (ctl_clk),
		.resetn  (resetn),
		.br_init (br_init),
		.br_wr_en(br_wr_en),
		.br_data (br_data),
		.rd_addr0(rd_addr0),
		.rd_addr1(rd_addr1),
		.rd_data0(rd_data0),
		.rd_data1(rd_data1)
	);

	motion_channel #(
		.C_STEP_NUMBER_WIDTH  (C_STEP_NUMBER_WIDTH),
		.C_SPEED_DATA_WIDTH   (C_SPEED_DATA_WIDTH),
		.C_SPEED_ADDRESS_WIDTH(C_SPEED_ADDRESS_WIDTH),
		.C_MICROSTEP_WIDTH    (C_MICROSTEP_WIDTH),
		.C_CLK_DIV_NBR        (C_CLK_DIV_NBR),
		.C_ZPD_SEQ            (C_ZPD_SEQ)
	) u_ch0 (
		.ctl_clk(ctl_clk),
		.resetn (resetn),
		.br_init(br_init),
		.cmd    (cmd0.sink),
		.stroke (s0_stroke),
		.zpd    (m0_zpd),
		.xen_in (s0_xen),
		.xrst_in(s0_xrst),
		.drive  (m0_drive),
		.dir    (m0_dir),
		.ms     (m0_ms),
		.xen    (m0_xen),
		.xrst   (m0_xrst),
		.zpsign (s0_zpsign),
		.tpsign (s0_tpsign),
		.pos    (s0_pos),
		.rd_addr(rd_addr0),
		.rd_data(rd_data0)
	);

	motion_channel #(
		.C_STEP_NUMBER_WIDTH  (C_STEP_NUMBER_WIDTH),
		.C_SPEED_DATA_WIDTH   (C_SPEED_DATA_WIDTH),
		.C_SPEED_ADDRESS_WIDTH(C_SPEED_ADDRESS_WIDTH),
		.C_MICROSTEP_WIDTH    (C_MICROSTEP_WIDTH),
		.C_CLK_DIV_NBR        (C_CLK_DIV_NBR),
		.C_ZPD_SEQ            (C_ZPD_SEQ)
	) u_ch1 (
		.ctl_clk(ctl_clk),
		.resetn (resetn),
		.br_init(br_init),
		.cmd    (cmd1.sink),
		.stroke (s1_stroke),
		.zpd    (m1_zpd),
		.xen_in (s1_xen),
		.xrst_in(s1_xrst),
		.drive  (m1_drive),
		.dir    (m1_dir),
		.ms     (m1_ms),
		.xen    (m1_xen),
		.xrst   (m1_xrst),
		.zpsign (s1_zpsign),
		.tpsign (s1_tpsign),
		.pos    (s1_pos),
		.rd_addr(rd_addr1),
		.rd_data(rd_data1)
	);

endmodule

//--- src/motion_channel.sv
`timescale 1ns/100ps

module motion_channel #(
	parameter int C_STEP_NUMBER_WIDTH   = 16,
	parameter int C_SPEED_DATA_WIDTH    = 16,
	parameter int C_SPEED_ADDRESS_WIDTH = 4,
	parameter int C_MICROSTEP_WIDTH     = 3,
	parameter int C_CLK_DIV_NBR         = 8,
	parameter logic [stepper_pkg::ZPD_LEN-1:0] C_ZPD_SEQ = 8'b1100_1010
) (
	input  logic                             ctl_clk,
	input  logic                             resetn,
	input  logic                             br_init,
	motor_cmd_if.sink                        cmd,
	input  logic [C_STEP_NUMBER_WIDTH-1:0]   stroke,
	input  logic                             zpd,
	input  logic                             xen_in,
	input  logic                             xrst_in,
	output logic                             drive,
	output logic                             dir,
	output logic [C_MICROSTEP_WIDTH-1:0]     ms,
	output logic                             xen,
	output logic                             xrst,
	output logic                             zpsign,
	output logic                             tpsign,
	output logic [C_STEP_NUMBER_WIDTH-1:0]   pos,
	output logic [C_SPEED_ADDRESS_WIDTH-1:0] rd_addr,
	input  logic [C_SPEED_DATA_WIDTH-1:0]    rd_data
);
	stepper_pkg::run_state_e            state;
	logic [stepper_pkg::ZPD_LEN-1:0]    zpd_sr;
	logic [C_STEP_NUMBER_WIDTH-1:0]     room;
	logic [C_STEP_NUMBER_WIDTH-1:0]     steps_clip;
	logic                               accept;
	logic                               zpd_hit;
	logic                               zero_seen;	// move was ended by the zero point
	logic                               halt_req;

	ramp_if #(
		.C_STEP_NUMBER_WIDTH(C_STEP_NUMBER_WIDTH),
		.C_SPEED_DATA_WIDTH (C_SPEED_DATA_WIDTH)
	) rmp ();

	ramp_timer #(
		.C_STEP_NUMBER_WIDTH  (C_STEP_NUMBER_WIDTH),
		.C_SPEED_DATA_WIDTH   (C_SPEED_DATA_WIDTH),
		.C_SPEED_ADDRESS_WIDTH(C_SPEED_ADDRESS_WIDTH),
		.C_CLK_DIV_NBR        (C_CLK_DIV_NBR)
	) u_timer (
		.ctl_clk(ctl_clk),
		.resetn (resetn),
		.rmp    (rmp.timer),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	assign cmd.ready = (state == stepper_pkg::IDLE) && !br_init;
	assign accept    = cmd.valid && cmd.ready;
	assign zpd_hit   = zpd_sr == C_ZPD_SEQ;	// oldest sample in the top bit
	assign drive     = rmp.tick;
	assign tpsign    = pos == stroke;
	assign rmp.halt  = halt_req;

	// forward moves may not pass the stroke, backward moves may not pass zero
	always_comb begin
		if (cmd.dir)
			room = (pos >= stroke) ? '0 : stroke - pos;
		else
			room = pos;
		steps_clip = (cmd.steps < room) ? cmd.steps : room;
	end

	// ========================================================================
	// run state machine
	// ========================================================================

	always_ff @(posedge ctl_clk) begin
		if (!resetn) begin
			state     <= stepper_pkg::IDLE;
			halt_req  <= 1'b0;
			zero_seen <= 1'b0;
			rmp.go    <= 1'b0;
		end else begin
			rmp.go <= accept;	// timer starts counting on the next edge
			case (state)
				stepper_pkg::IDLE: begin
					if (accept) begin
						state     <= stepper_pkg::RUN;
						zero_seen <= 1'b0;
					end
				end
				stepper_pkg::RUN: begin
					if (rmp.done) begin
						state <= stepper_pkg::IDLE;
					end else if (cmd.stop || (zpd_hit && !dir)) begin
						state     <= stepper_pkg::HALT;
						halt_req  <= 1'b1;
						zero_seen <= zpd_hit && !dir;
					end
				end
				stepper_pkg::HALT: begin
					if (rmp.done) begin
						state    <= stepper_pkg::IDLE;
						halt_req <= 1'b0;
					end
				end
				default: state <= stepper_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge ctl_clk) begin
		if (accept) begin
			dir       <= cmd.dir;
			ms        <= cmd.ms;
			rmp.total <= steps_clip;
			rmp.speed <= cmd.speed;
		end
	end

	// ========================================================================
	// position, signs and pass-through outputs
	// ========================================================================

	always_ff @(posedge ctl_clk) begin
		if (!resetn) begin
			pos    <= '0;
			zpsign <= 1'b0;
			zpd_sr <= '0;
			xen    <= 1'b0;
			xrst   <= 1'b0;
		end else begin
			zpd_sr <= {zpd_sr[stepper_pkg::ZPD_LEN-2:0], zpd};
			xen    <= xen_in;
			xrst   <= xrst_in;
			if (rmp.done && zero_seen) begin
				pos    <= '0;	// the zero point defines the origin
				zpsign <= 1'b1;
			end else if (rmp.tick) begin
				pos <= dir ? pos + 1'b1 : pos - 1'b1;
			end
			if (accept && cmd.dir)
				zpsign <= 1'b0;
		end
	end

endmodule

//--- src/ramp_timer.sv
`timescale 1ns/100ps

module ramp_timer #(
	parameter int C_STEP_NUMBER_WIDTH   = 16,
	parameter int C_SPEED_DATA_WIDTH    = 16,
	parameter int C_SPEED_ADDRESS_WIDTH = 4,
	parameter int C_CLK_DIV_NBR         = 8
) (
	input  logic                             ctl_clk,
	input  logic                             resetn,
	ramp_if.timer                            rmp,
	output logic [C_SPEED_ADDRESS_WIDTH-1:0] rd_addr,
	input  logic [C_SPEED_DATA_WIDTH-1:0]    rd_data
);
	localparam int DIV_W = (C_CLK_DIV_NBR > 1) ? $clog2(C_CLK_DIV_NBR) : 1;
	localparam int DEPTH = 2 ** C_SPEED_ADDRESS_WIDTH;

	logic                           running;
	logic [DIV_W-1:0]               div_cnt;	// ctl_clk cycles inside one period unit
	logic [C_SPEED_DATA_WIDTH-1:0]  unit_cnt;	// period units inside one step
	logic [C_SPEED_DATA_WIDTH-1:0]  floor_q;
	logic [C_SPEED_DATA_WIDTH-1:0]  period;
	logic [C_SPEED_DATA_WIDTH-1:0]  unit_last;
	logic [C_STEP_NUMBER_WIDTH-1:0] step_cnt;	// steps already emitted
	logic [C_STEP_NUMBER_WIDTH-1:0] left_cnt;	// steps still to come, current one included
	logic [C_STEP_NUMBER_WIDTH-1:0] idx_dn;
	logic [C_STEP_NUMBER_WIDTH-1:0] idx_sel;
	logic                           div_wrap;
	logic                           last_step;

	// ========================================================================
	// ramp index and period length
	// ========================================================================

	assign idx_dn = left_cnt - 1'b1;	// distance to the end of the move

	always_comb begin
		idx_sel = (step_cnt < idx_dn) ? step_cnt : idx_dn;
		if (idx_sel > (DEPTH - 1))
			rd_addr = C_SPEED_ADDRESS_WIDTH'(DEPTH - 1);	// cruise at the last entry
		else
			rd_addr = idx_sel[C_SPEED_ADDRESS_WIDTH-1:0];
	end

	assign period    = (rd_data > floor_q) ? rd_data : floor_q;
	assign unit_last = (period == '0) ? '0 : period - 1'b1;	// a zero period counts as one unit
	assign div_wrap  = div_cnt == DIV_W'(C_CLK_DIV_NBR - 1);
	assign last_step = (left_cnt == 1) || rmp.halt;

	assign rmp.tick = running && div_wrap && (unit_cnt == unit_last);

	// ========================================================================
	// counters
	// ========================================================================

	always_ff @(posedge ctl_clk) begin
		if (!resetn) begin
			running  <= 1'b0;
			rmp.done <= 1'b0;
			div_cnt  <= '0;
			unit_cnt <= '0;
			step_cnt <= '0;
			left_cnt <= '0;
		end else begin
			rmp.done <= 1'b0;
			if (rmp.go) begin
				div_cnt  <= '0;
				unit_cnt <= '0;
				step_cnt <= '0;
				left_cnt <= rmp.total;
				running  <= rmp.total != '0;
				rmp.done <= rmp.total == '0;	// empty move ends right away
			end else if (running) begin
				if (!div_wrap) begin
					div_cnt <= div_cnt + 1'b1;
				end else begin
					div_cnt <= '0;
					if (!rmp.tick) begin
						unit_cnt <= unit_cnt + 1'b1;
					end else begin
						unit_cnt <= '0;
						step_cnt <= step_cnt + 1'b1;
						left_cnt <= left_cnt - 1'b1;
						if (last_step) begin
							running  <= 1'b0;
							rmp.done <= 1'b1;
						end
					end
				end
			end
		end
	end

	always_ff @(posedge ctl_clk) begin
		if (rmp.go)
			floor_q <= rmp.speed;
	end

endmodule

//--- src/speed_table.sv
`timescale 1ns/100ps

module speed_table #(
	parameter int C_SPEED_DATA_WIDTH    = 16,
	parameter int C_SPEED_ADDRESS_WIDTH = 4
) (
	input  logic                             ctl_clk,
	input  logic                             resetn,
	input  logic                             br_init,
	input  logic                             br_wr_en,
	input  logic [C_SPEED_DATA_WIDTH-1:0]    br_data,
	input  logic [C_SPEED_ADDRESS_WIDTH-1:0] rd_addr0,
	input  logic [C_SPEED_ADDRESS_WIDTH-1:0] rd_addr1,
	output logic [C_SPEED_DATA_WIDTH-1:0]    rd_data0,
	output logic [C_SPEED_DATA_WIDTH-1:0]    rd_data1
);
	localparam int DEPTH = 2 ** C_SPEED_ADDRESS_WIDTH;

	logic [C_SPEED_DATA_WIDTH-1:0]    mem [DEPTH];
	logic [C_SPEED_ADDRESS_WIDTH-1:0] wr_ptr;
	logic [C_SPEED_ADDRESS_WIDTH-1:0] wr_addr;

	assign wr_addr = br_init ? '0 : wr_ptr;	// init holds the write address at zero

	always_ff @(posedge ctl_clk) begin
		if (!resetn) begin
			wr_ptr <= '0;
		end else begin
			wr_ptr <= wr_addr + C_SPEED_ADDRESS_WIDTH'(br_wr_en);	// wraps at the depth
		end
	end

	always_ff @(posedge ctl_clk) begin
		if (br_wr_en)
			mem[wr_addr] <= br_data;
	end

	assign rd_data0 = mem[rd_addr0];	// both channels read without a clock
	assign rd_data1 = mem[rd_addr1];

endmodule

//--- src/ramp_if.sv
`timescale 1ns/100ps

interface ramp_if #(
	parameter int C_STEP_NUMBER_WIDTH = 16,
	parameter int C_SPEED_DATA_WIDTH  = 16
) ();
	logic                           go;	// start pulse, total and speed valid with it
	logic [C_STEP_NUMBER_WIDTH-1:0] total;	// step count after clipping
	logic [C_SPEED_DATA_WIDTH-1:0]  speed;	// floor for the table periods
	logic                           halt;	// end after the current period
	logic                           tick;	// last cycle of a period
	logic                           done;	// one cycle after the final tick

	modport ctrl (output go, total, speed, halt, input tick, done);

	modport timer (input go, total, speed, halt, output tick, done);

endinterface

//--- src/motor_cmd_if.sv
`timescale 1ns/100ps

interface motor_cmd_if #(
	parameter int C_STEP_NUMBER_WIDTH = 16,
	parameter int C_SPEED_DATA_WIDTH  = 16,
	parameter int C_MICROSTEP_WIDTH   = 3
) ();
	logic                           valid;	// command offered
	logic                           ready;	// channel idle and table not in init
	logic [C_SPEED_DATA_WIDTH-1:0]  speed;	// minimum period in table units
	logic [C_STEP_NUMBER_WIDTH-1:0] steps;
	logic                           dir;	// high moves towards the stroke end
	logic [C_MICROSTEP_WIDTH-1:0]   ms;
	logic                           stop;	// single cycle request, only seen in RUN

	modport source (output valid, speed, steps, dir, ms, stop, input ready);

	modport sink (input valid, speed, steps, dir, ms, stop, output ready);

endinterface

//--- src/stepper_pkg.sv
package stepper_pkg;

	// ========================================================================
	// channel run states
	// ========================================================================

	typedef enum logic [1:0] {
		IDLE = 2'b00,	// waiting for a command, ready may be high
		RUN  = 2'b01,	// pulses are being emitted
		HALT = 2'b10	// stop or zero point seen, last period finishing
	} run_state_e;

	// ========================================================================
	// zero point detection
	// ========================================================================

	// the zero pattern is compared over this many consecutive samples of zpd;
	// the oldest sample sits in the top bit of the pattern
	localparam int ZPD_LEN = 8;

endpackage
